/* compile.f */
+incdir+include
hdl/bpu_pkg.sv
hdl/bpf.sv
hdl/bpu_btb.sv
hdl/bpu_lpht.sv
hdl/bpu_ras.sv
hdl/bpu.sv
hdl/branch_unit.sv
test/tb_branch_unit.sv

/* hdl/bpf.sv */
// branch feedback in execute
// resolves one branch, checks it against its prediction, builds the update record

`timescale 1ns/1ps
`default_nettype none

`include "bpu_params.svh"

module bpf (
	input  logic                  clk,
	input  logic                  rst_i,
	input  logic                  csr_flush_i,
	input  logic                  stall_i,
	input  logic [31:0]           pc_i,
	input  logic [31:0]           rj_i,
	input  logic [31:0]           rd_i,
	input  logic [31:0]           csr_target_i,
	input  bpu_pkg::decode_info_t decode_i,
	input  bpu_pkg::bpu_predict_t predict_i,
	output bpu_pkg::bpu_update_t  update_o,
	output logic [31:0]           link_pc_o
);
	import bpu_pkg::*;

	logic        br_valid;
	logic        taken;
	logic [31:0] offs_26;
	logic [31:0] offs_16;
	logic [31:0] next_pair;
	logic [31:0] target;
	logic        predict_taken;
	logic        miss_flush;
	br_kind_t    kind;
	logic [1:0]  redirect;

	assign br_valid = decode_i.valid & (decode_i.branch_type != branch_invalid);

	// sign extended word offsets
	assign offs_26 = {{4{decode_i.field.offs.lo[9]}}, decode_i.field.offs.lo,
		decode_i.field.offs.hi, 2'b00};
	assign offs_16 = {{14{decode_i.field.offs.hi[15]}}, decode_i.field.offs.hi, 2'b00};
	assign next_pair = {pc_i[31:3] + 29'd1, 3'b000};

	// ------------------------------------------------------------
	// direction and target
	// ------------------------------------------------------------
	always_comb begin
		taken = 1'b0;
		if (decode_i.branch_type == branch_condition) begin
			case (decode_i.cmp_type)
				cmp_eq:  taken = rj_i == rd_i;
				cmp_ne:  taken = rj_i != rd_i;
				cmp_lt:  taken = $signed(rj_i) < $signed(rd_i);
				cmp_ge:  taken = $signed(rj_i) >= $signed(rd_i);
				cmp_ltu: taken = rj_i < rd_i;
				cmp_geu: taken = rj_i >= rd_i;
				cmp_le:  taken = $signed(rj_i) <= $signed(rd_i);
				cmp_gt:  taken = $signed(rj_i) > $signed(rd_i);
				default: taken = 1'b0;
			endcase
		end else if (decode_i.branch_type != branch_invalid) begin
			taken = 1'b1;
		end
	end

	always_comb begin
		case (decode_i.branch_type)
			branch_immediate: target = pc_i + offs_26;
			branch_indirect:  target = rj_i + offs_16;
			branch_condition: target = taken ? pc_i + offs_16 : next_pair;
			default:          target = next_pair;
		endcase
	end

	// prediction only counts for the slot it was made for
	assign predict_taken = (predict_i.fsc == pc_i[2]) ? predict_i.taken : 1'b0;

	// direction miss, or wrong target on a taken prediction
	assign miss_flush = br_valid & ~stall_i & ((predict_taken != taken)
		| (predict_i.taken & ({predict_i.npc, 2'b00} != target)));

	assign link_pc_o = pc_i + 32'd4;

	// ------------------------------------------------------------
	// branch kind and ras repair
	// ------------------------------------------------------------
	always_comb begin
		if ((decode_i.branch_type == branch_indirect && decode_i.field.regs.rd == 5'd1)
			|| decode_i.branch_link) begin
			kind = kind_call;
		end else if (decode_i.branch_type == branch_indirect
			&& decode_i.field.regs.rj == 5'd1 && decode_i.field.offs.hi == 16'd0) begin
			kind = kind_return;
		end else if (decode_i.branch_type == branch_immediate
			|| decode_i.branch_type == branch_indirect) begin
			kind = kind_absolute;
		end else begin
			kind = kind_pc_relative;
		end
	end

	always_comb begin
		if (stall_i || !br_valid) begin
			redirect = 2'd0;
		end else if (kind == kind_call && predict_i.br_type != kind_call) begin
			redirect = 2'd2;
		end else if (kind == kind_return && predict_i.br_type != kind_return) begin
			redirect = 2'd1;
		end else begin
			// any other miss just restores the pointer
			redirect = {1'b0, miss_flush};
		end
	end

	// update record
	always_comb begin
		update_o.flush = miss_flush | csr_flush_i;
		update_o.br_taken = taken;
		update_o.pc = pc_i[31:2];
		if (csr_flush_i) begin
			update_o.br_target = csr_target_i;
		end else if (!pc_i[2] && !taken && predict_i.taken) begin
			// falsely taken slot 0, refetch slot 1
			update_o.br_target = pc_i + 32'd4;
		end else begin
			update_o.br_target = target;
		end
		update_o.btb_update = br_valid & ~stall_i;
		update_o.lpht_update = br_valid & ~stall_i;
		update_o.br_type = kind;
		update_o.lphr = predict_i.lphr;
		update_o.lphr_index = pc_i[`BPU_LPHT_ADDR_WIDTH+1:2];
		case (kind)
			kind_call:   update_o.ras_ptr = predict_i.ras_ptr + 1'b1;
			kind_return: update_o.ras_ptr = predict_i.ras_ptr - 1'b1;
			default:     update_o.ras_ptr = predict_i.ras_ptr;
		endcase
		update_o.ras_redirect = redirect;
	end

	// held instruction must not redirect fetch, only the csr unit may
	a_no_flush_in_stall: assert property (@(posedge clk) disable iff (rst_i)
		(stall_i && !csr_flush_i) |-> !update_o.flush);

	// decoder contract on bubbles
	a_bubble_invalid: assert property (@(posedge clk) disable iff (rst_i)
		!decode_i.valid |-> decode_i.branch_type == branch_invalid);

endmodule : bpf

`default_nettype wire

/* hdl/bpu.sv */
// branch predictor
// merges btb, local history and return stack into one prediction per fetch pair

`timescale 1ns/1ps
`default_nettype none

`include "bpu_params.svh"

module bpu (
	input  logic                  clk,
	input  logic                  rst_i,
	input  logic [31:0]           fetch_pc_i,
	input  bpu_pkg::bpu_update_t  update_i,
	output bpu_pkg::bpu_predict_t predict_o
);
	import bpu_pkg::*;

	logic                          btb_hit;
	logic [29:0]                   btb_target;
	logic                          btb_fsc;
	br_kind_t                      btb_kind;
	logic [29:0]                   slot_pc;
	logic [`BPU_LPHR_WIDTH-1:0]    lphr;
	logic                          counter_taken;
	logic                          ras_push;
	logic                          ras_pop;
	logic [29:0]                   ras_top;
	logic [`BPU_RAS_DEPTH_LOG-1:0] ras_ptr;
	logic [29:0]                   next_pair;
	logic                          pred_taken;

	// word address of the branch slot named by the btb, slot 0 on a miss
	assign slot_pc = {fetch_pc_i[31:3], btb_hit & btb_fsc};
	assign next_pair = {fetch_pc_i[31:3] + 29'd1, 1'b0};

	bpu_btb btb0 (
		.clk         (clk),
		.rst_i       (rst_i),
		.lookup_pc_i (fetch_pc_i[31:2]),
		.hit_o       (btb_hit),
		.target_o    (btb_target),
		.fsc_o       (btb_fsc),
		.kind_o      (btb_kind),
		.update_i    (update_i)
	);

	bpu_lpht lpht0 (
		.clk             (clk),
		.rst_i           (rst_i),
		.lookup_pc_i     (slot_pc),
		.lphr_o          (lphr),
		.counter_taken_o (counter_taken),
		.update_i        (update_i)
	);

	// calls push the return slot, returns pop
	assign ras_push = btb_hit & (btb_kind == kind_call);
	assign ras_pop = btb_hit & (btb_kind == kind_return);

	bpu_ras ras0 (
		.clk         (clk),
		.rst_i       (rst_i),
		.push_i      (ras_push),
		.push_addr_i (slot_pc + 30'd1),
		.pop_i       (ras_pop),
		.top_o       (ras_top),
		.ptr_o       (ras_ptr),
		.update_i    (update_i)
	);

	// ------------------------------------------------------------
	// prediction
	// ------------------------------------------------------------
	// jumps always taken, pc relative follows the counter
	assign pred_taken = btb_hit & ((btb_kind != kind_pc_relative) | counter_taken);

	always_comb begin
		predict_o.taken = pred_taken;
		predict_o.fsc = btb_hit & btb_fsc;
		predict_o.lphr = lphr;
		predict_o.ras_ptr = ras_ptr;
		predict_o.br_type = btb_hit ? btb_kind : kind_pc_relative;
		if (!pred_taken) begin
			predict_o.npc = next_pair;
		end else if (btb_kind == kind_return) begin
			predict_o.npc = ras_top;
		end else begin
			predict_o.npc = btb_target;
		end
	end

endmodule : bpu

`default_nettype wire

/* hdl/bpu_btb.sv */
// branch target buffer
// direct mapped on the pair address, holds tag, target, slot and kind

`timescale 1ns/1ps
`default_nettype none

`include "bpu_params.svh"

module bpu_btb (
	input  logic                 clk,
	input  logic                 rst_i,
	input  logic [29:0]          lookup_pc_i,
	output logic                 hit_o,
	output logic [29:0]          target_o,
	output logic                 fsc_o,
	output bpu_pkg::br_kind_t    kind_o,
	input  bpu_pkg::bpu_update_t update_i
);
	import bpu_pkg::*;

	localparam int AW = `BPU_BTB_ADDR_WIDTH;
	localparam int TW = `BPU_BTB_TAG_WIDTH;
	localparam int DEPTH = 1 << AW;

	typedef struct packed {
		logic [TW-1:0] tag;
		logic [29:0]   target;
		logic          fsc;
		br_kind_t      kind;
	} btb_entry_t;

	logic [DEPTH-1:0] valid_q;
	btb_entry_t       entry_q [DEPTH];
	logic [AW-1:0]    rd_idx;
	logic [TW-1:0]    rd_tag;
	logic [AW-1:0]    wr_idx;
	btb_entry_t       rd_entry;
	btb_entry_t       wr_entry;
	logic             wr_en;

	// bit 0 of the word address is the slot, the pair starts at bit 1
	assign rd_idx = lookup_pc_i[AW:1];
	assign rd_tag = lookup_pc_i[AW+TW:AW+1];
	assign rd_entry = entry_q[rd_idx];

	assign hit_o = valid_q[rd_idx] && (rd_entry.tag == rd_tag);
	assign target_o = rd_entry.target;
	assign fsc_o = rd_entry.fsc;
	assign kind_o = rd_entry.kind;

	// only taken branches allocate
	assign wr_en = update_i.btb_update & update_i.br_taken;
	assign wr_idx = update_i.pc[AW:1];

	always_comb begin
		wr_entry.tag = update_i.pc[AW+TW:AW+1];
		wr_entry.target = update_i.br_target[31:2];
		wr_entry.fsc = update_i.pc[0];
		wr_entry.kind = update_i.br_type;
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			valid_q <= '0;
		end else if (wr_en) begin
			valid_q[wr_idx] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en) begin
			entry_q[wr_idx] <= wr_entry;
		end
	end

endmodule : bpu_btb

`default_nettype wire

/* hdl/bpu_lpht.sv */
// local history predictor
// per-pc history registers select 2-bit saturating counters

`timescale 1ns/1ps
`default_nettype none

`include "bpu_params.svh"

module bpu_lpht (
	input  logic                       clk,
	input  logic                       rst_i,
	input  logic [29:0]                lookup_pc_i,
	output logic [`BPU_LPHR_WIDTH-1:0] lphr_o,
	output logic                       counter_taken_o,
	input  bpu_pkg::bpu_update_t       update_i
);
	localparam int HW = `BPU_LPHR_WIDTH;
	localparam int LPHT_DEPTH = 1 << `BPU_LPHT_ADDR_WIDTH;
	localparam int PHT_DEPTH = 1 << HW;

	logic [HW-1:0]                   lphr_q [LPHT_DEPTH];
	logic [1:0]                      pht_q [PHT_DEPTH];
	logic [`BPU_LPHT_ADDR_WIDTH-1:0] rd_idx;
	logic [HW-1:0]                   rd_hist;
	logic [HW-1:0]                   hist_next;
	logic [1:0]                      cnt_cur;
	logic [1:0]                      cnt_next;

	// lookup
	assign rd_idx = lookup_pc_i[`BPU_LPHT_ADDR_WIDTH-1:0];
	assign rd_hist = lphr_q[rd_idx];
	assign lphr_o = rd_hist;
	assign counter_taken_o = pht_q[rd_hist][1];

	// shifted history, also picks the counter so the next lookup sees the training
	assign hist_next = {update_i.lphr[HW-2:0], update_i.br_taken};
	assign cnt_cur = pht_q[hist_next];

	always_comb begin
		cnt_next = cnt_cur;
		if (update_i.br_taken && cnt_cur != 2'd3) begin
			cnt_next = cnt_cur + 2'd1;
		end else if (!update_i.br_taken && cnt_cur != 2'd0) begin
			cnt_next = cnt_cur - 2'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			for (int i = 0; i < LPHT_DEPTH; i++) begin
				lphr_q[i] <= '0;
			end
		end else if (update_i.lpht_update) begin
			lphr_q[update_i.lphr_index] <= hist_next;
		end
	end

	// weakly not taken after reset
	always_ff @(posedge clk) begin
		if (rst_i) begin
			for (int i = 0; i < PHT_DEPTH; i++) begin
				pht_q[i] <= 2'b01;
			end
		end else if (update_i.lpht_update) begin
			pht_q[hist_next] <= cnt_next;
		end
	end

	// counters saturate, never wrap between 0 and 3
	a_cnt_range: assert property (@(posedge clk) disable iff (rst_i)
		update_i.lpht_update |=>
			!(pht_q[$past(hist_next)] == 2'd0 && $past(cnt_cur) == 2'd3)
			&& !(pht_q[$past(hist_next)] == 2'd3 && $past(cnt_cur) == 2'd0));

endmodule : bpu_lpht

`default_nettype wire

/* hdl/bpu_pkg.sv */
// branch prediction types
// decode view, instruction field views and the records passed fetch to execute

`default_nettype none

`include "bpu_params.svh"

package bpu_pkg;

	// branch class from the decoder
	typedef enum logic [1:0] {
		branch_invalid,
		branch_condition,
		branch_immediate,
		branch_indirect
	} branch_type_t;

	// compare kind of a conditional branch, rj against rd
	typedef enum logic [2:0] {
		cmp_eq,
		cmp_ne,
		cmp_lt,
		cmp_ge,
		cmp_ltu,
		cmp_geu,
		cmp_le,
		cmp_gt
	} cmp_type_t;

	// kind stored in the btb, picks the target source
	typedef enum logic [1:0] {
		kind_pc_relative,
		kind_absolute,
		kind_call,
		kind_return
	} br_kind_t;

	// ------------------------------------------------------------
	// 26-bit instruction field
	// ------------------------------------------------------------

	// offset view, lo holds the upper part of a 26-bit offset
	typedef struct packed {
		logic [15:0] hi;
		logic [9:0]  lo;
	} offs_field_t;

	// register view
	typedef struct packed {
		logic [15:0] upper;
		logic [4:0]  rj;
		logic [4:0]  rd;
	} reg_field_t;

	typedef union packed {
		offs_field_t offs;
		reg_field_t  regs;
	} inst_field_u;

	// decoded instruction, 33 bits
	typedef struct packed {
		logic         valid;
		branch_type_t branch_type;
		cmp_type_t    cmp_type;
		logic         branch_link;
		inst_field_u  field;
	} decode_info_t;

	// ------------------------------------------------------------
	// prediction and update records
	// ------------------------------------------------------------

	// npc is a word address
	typedef struct packed {
		logic [29:0]                   npc;
		logic                          taken;
		logic                          fsc;
		logic [`BPU_LPHR_WIDTH-1:0]    lphr;
		logic [`BPU_RAS_DEPTH_LOG-1:0] ras_ptr;
		br_kind_t                      br_type;
	} bpu_predict_t;

	// ras_redirect: 2 repairs a call, 1 repairs a return or restores the pointer
	typedef struct packed {
		logic                            flush;
		logic                            br_taken;
		logic [29:0]                     pc;
		logic [31:0]                     br_target;
		logic                            btb_update;
		logic                            lpht_update;
		br_kind_t                        br_type;
		logic [`BPU_LPHR_WIDTH-1:0]      lphr;
		logic [`BPU_LPHT_ADDR_WIDTH-1:0] lphr_index;
		logic [`BPU_RAS_DEPTH_LOG-1:0]   ras_ptr;
		logic [1:0]                      ras_redirect;
	} bpu_update_t;

endpackage : bpu_pkg

`default_nettype wire

/* hdl/bpu_ras.sv */
// return address stack
// circular, pointer restored from execute after a misprediction

`timescale 1ns/1ps
`default_nettype none

`include "bpu_params.svh"

module bpu_ras (
	input  logic                          clk,
	input  logic                          rst_i,
	input  logic                          push_i,
	input  logic [29:0]                   push_addr_i,
	input  logic                          pop_i,
	output logic [29:0]                   top_o,
	output logic [`BPU_RAS_DEPTH_LOG-1:0] ptr_o,
	input  bpu_pkg::bpu_update_t          update_i
);
	localparam int PW = `BPU_RAS_DEPTH_LOG;
	localparam int DEPTH = 1 << PW;

	logic [29:0]   stack_q [DEPTH];
	logic [PW-1:0] ptr_q;
	logic [PW-1:0] top_idx;
	logic [PW-1:0] repair_idx;

	// ptr is the next free slot
	assign top_idx = ptr_q - 1'b1;
	assign top_o = stack_q[top_idx];
	assign ptr_o = ptr_q;

	// repaired call sits just below the restored pointer
	assign repair_idx = update_i.ras_ptr - 1'b1;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			ptr_q <= '0;
		end else if (update_i.ras_redirect != 2'd0) begin
			ptr_q <= update_i.ras_ptr;
		end else if (push_i) begin
			ptr_q <= ptr_q + 1'b1;
		end else if (pop_i) begin
			ptr_q <= ptr_q - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (update_i.ras_redirect == 2'd2) begin
			stack_q[repair_idx] <= update_i.pc + 30'd1;
		end else if (push_i && update_i.ras_redirect == 2'd0) begin
			stack_q[ptr_q] <= push_addr_i;
		end
	end

	// one btb hit cannot be both call and return
	a_push_pop: assert property (@(posedge clk) disable iff (rst_i)
		!(push_i && pop_i));

endmodule : bpu_ras

`default_nettype wire

/* hdl/branch_unit.sv */
// branch prediction loop top
// predictor on the fetch side, feedback block on the execute side

`timescale 1ns/1ps
`default_nettype none

module branch_unit (
	input  logic                  clk,
	input  logic                  rst_i,
	input  logic [31:0]           fetch_pc_i,
	output bpu_pkg::bpu_predict_t predict_o,
	input  logic                  csr_flush_i,
	input  logic                  stall_i,
	input  logic [31:0]           pc_i,
	input  logic [31:0]           rj_i,
	input  logic [31:0]           rd_i,
	input  logic [31:0]           csr_target_i,
	input  bpu_pkg::decode_info_t decode_i,
	input  bpu_pkg::bpu_predict_t predict_i,
	output bpu_pkg::bpu_update_t  update_o,
	output logic [31:0]           link_pc_o
);

	// update record trains the tables
	bpu bpu0 (
		.clk        (clk),
		.rst_i      (rst_i),
		.fetch_pc_i (fetch_pc_i),
		.update_i   (update_o),
		.predict_o  (predict_o)
	);

	bpf bpf0 (
		.clk          (clk),
		.rst_i        (rst_i),
		.csr_flush_i  (csr_flush_i),
		.stall_i      (stall_i),
		.pc_i         (pc_i),
		.rj_i         (rj_i),
		.rd_i         (rd_i),
		.csr_target_i (csr_target_i),
		.decode_i     (decode_i),
		.predict_i    (predict_i),
		.update_o     (update_o),
		.link_pc_o    (link_pc_o)
	);

endmodule : branch_unit

`default_nettype wire

/* include/bpu_params.svh */
// branch predictor sizing
// table depths and field widths shared by the predictor and the feedback block

`ifndef BPU_PARAMS_SVH
`define BPU_PARAMS_SVH

// local history table index, 256 entries
`define BPU_LPHT_ADDR_WIDTH 8

// local history bits per entry, also the pattern table index
`define BPU_LPHR_WIDTH 4

// btb index, 64 entries
`define BPU_BTB_ADDR_WIDTH 6

// btb tag bits above the index
`define BPU_BTB_TAG_WIDTH 8

// log2 of the return stack depth
`define BPU_RAS_DEPTH_LOG 3

`endif

/* run.sh */
#!/bin/sh
# build and run the branch unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f --top-module tb_branch_unit -o tb_branch_unit

./obj_dir/tb_branch_unit > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log

if grep -q "Checks failed" sim.log; then
	exit 1
fi
exit 0

/* test/branch_patterns.mem */
// pc ctrl(0 valid type cmp link stall csr rnd) field rj rd csr_target
// expected flags(br_taken flush predict_taken ras_redirect) expected target
00001010 01200000 00004000 00000000 00000000 00000000 00001101 00001050
00001010 01200000 00004000 00000000 00000000 00000000 00001010 00001050
00002020 01100000 00002000 00000005 00000005 00000000 00001101 00002040
00002020 01100000 00002000 00000005 00000005 00000000 00001010 00002040
00003008 01100000 00004000 00000000 00000000 00000000 00001101 00003048
00003010 01110000 00004000 80000000 80000000 00000000 00000000 00003018
00003018 01120000 00004000 80000000 00000001 00000000 00001101 00003058
00003020 01130000 00004000 80000000 00000001 00000000 00000000 00003028
00003028 01140000 00004000 80000000 00000001 00000000 00000000 00003030
00003030 01150000 00004000 80000000 00000001 00000000 00001101 00003070
00003038 01160000 00004000 ffffffff ffffffff 00000000 00001101 00003078
00003040 01170000 00004000 00000000 00000000 00000000 00000000 00003048
00004008 01100001 00004000 00000000 00000000 00000000 00000000 00000000
00004010 01110001 00004000 00000000 00000000 00000000 00000000 00000000
00004018 01120001 00004000 00000000 00000000 00000000 00000000 00000000
00004020 01130001 00004000 00000000 00000000 00000000 00000000 00000000
00004028 01140001 00004000 00000000 00000000 00000000 00000000 00000000
00004030 01150001 00004000 00000000 00000000 00000000 00000000 00000000
00004038 01160001 00004000 00000000 00000000 00000000 00000000 00000000
00004040 01170001 00004000 00000000 00000000 00000000 00000000 00000000
00005008 01201000 000ff800 00000000 00000000 00000000 00001102 00006000
00006010 01300000 00000020 0000500c 00000000 00000000 00001101 0000500c
00005008 01201000 000ff800 00000000 00000000 00000000 00001010 00006000
00006010 01300000 00000020 0000500c 00000000 00000000 00001010 0000500c
00007010 01200100 00004000 00000000 00000000 00000000 00001000 00007050
00007010 01200000 00004000 00000000 00000000 00000000 00001101 00007050
00008000 00000110 00000000 00000000 00000000 1c000000 00000100 1c000000
00007010 01200110 00004000 00000000 00000000 1c000008 00001110 1c000008

/* test/tb_branch_unit.sv */
// branch unit testbench
// replays branch records from a patterns file through lookup and resolve, checks the update

`timescale 1ns/1ps
`default_nettype none

module tb_branch_unit;
	import bpu_pkg::*;

	localparam int NUM_REC = 28;
	localparam int REC_WORDS = 8;
	// two cycles per record, plenty of margin
	localparam int CYCLE_LIMIT = NUM_REC * 4 + 50;

	logic         clk;
	logic         rst_i;
	logic [31:0]  fetch_pc_i;
	logic         csr_flush_i;
	logic         stall_i;
	logic [31:0]  pc_i;
	logic [31:0]  rj_i;
	logic [31:0]  rd_i;
	logic [31:0]  csr_target_i;
	decode_info_t decode_i;
	bpu_predict_t predict_i;
	bpu_predict_t predict_o;
	bpu_update_t  update_o;
	logic [31:0]  link_pc_o;

	logic [31:0] pat [NUM_REC*REC_WORDS];
	logic [31:0] lfsr_state;
	int          errors;
	int          checks;
	int          cycles;

	branch_unit dut0 (
		.clk          (clk),
		.rst_i        (rst_i),
		.fetch_pc_i   (fetch_pc_i),
		.predict_o    (predict_o),
		.csr_flush_i  (csr_flush_i),
		.stall_i      (stall_i),
		.pc_i         (pc_i),
		.rj_i         (rj_i),
		.rd_i         (rd_i),
		.csr_target_i (csr_target_i),
		.decode_i     (decode_i),
		.predict_i    (predict_i),
		.update_o     (update_o),
		.link_pc_o    (link_pc_o)
	);

	always #50 clk = ~clk;

	// run limit
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Checks failed");
			$finish;
		end
	end

	// ------------------------------------------------------------
	// helpers
	// ------------------------------------------------------------
	// fibonacci lfsr, taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// one lfsr step per bit
	task automatic random_word(output logic [31:0] w);
		w = '0;
		for (int i = 0; i < 32; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			w = {w[30:0], lfsr_state[0]};
		end
	endtask

	// branch direction of the eight compare kinds, rj against rd
	function automatic logic compare_taken(input logic [2:0] c, input logic [31:0] a,
		input logic [31:0] b);
		case (c)
			3'd0: return a == b;
			3'd1: return a != b;
			3'd2: return $signed(a) < $signed(b);
			3'd3: return $signed(a) >= $signed(b);
			3'd4: return a < b;
			3'd5: return a >= b;
			3'd6: return $signed(a) <= $signed(b);
			default: return $signed(a) > $signed(b);
		endcase
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("MISMATCH %s: got %h expected %h", name, got, exp);
		end
	endtask

	// ------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------
	initial begin
		int           base;
		int           err_before;
		logic [31:0]  pc_v;
		logic [31:0]  ctrl;
		logic [31:0]  field_v;
		logic [31:0]  rj_v;
		logic [31:0]  rd_v;
		logic [31:0]  exp_flags;
		logic [31:0]  exp_target;
		logic [31:0]  offs_16;
		logic         rnd;
		decode_info_t dec;
		bpu_predict_t pred;

		clk = 1'b0;
		rst_i = 1'b1;
		fetch_pc_i = '0;
		csr_flush_i = 1'b0;
		stall_i = 1'b0;
		pc_i = '0;
		rj_i = '0;
		rd_i = '0;
		csr_target_i = '0;
		decode_i = '0;
		predict_i = '0;
		errors = 0;
		checks = 0;
		cycles = 0;
		lfsr_state = 32'h3364_f0b7;
		$readmemh("test/branch_patterns.mem", pat);

		repeat (2) @(posedge clk);
		rst_i <= 1'b0;

		for (int r = 0; r < NUM_REC; r++) begin
			base = r * REC_WORDS;
			pc_v = pat[base];
			ctrl = pat[base+1];
			field_v = pat[base+2];
			rj_v = pat[base+3];
			rd_v = pat[base+4];
			exp_flags = pat[base+6];
			exp_target = pat[base+7];
			rnd = ctrl[0];

			// lookup cycle, execute side idle
			@(posedge clk);
			fetch_pc_i <= pc_v;
			decode_i <= '0;
			stall_i <= 1'b0;
			csr_flush_i <= 1'b0;
			@(negedge clk);
			pred = predict_o;

			dec.valid = ctrl[24];
			dec.branch_type = branch_type_t'(ctrl[21:20]);
			dec.cmp_type = cmp_type_t'(ctrl[18:16]);
			dec.branch_link = ctrl[12];
			dec.field = field_v[25:0];

			// sweep records take lfsr operands, expected result worked out here
			if (rnd) begin
				random_word(rj_v);
				random_word(rd_v);
				// 16-bit word offset in field bits 25:10, as a byte offset
				offs_16 = {{16{field_v[25]}}, field_v[25:10]} << 2;
				exp_flags[12] = compare_taken(ctrl[18:16], rj_v, rd_v);
				if (exp_flags[12]) begin
					exp_target = pc_v + offs_16;
				end else begin
					exp_target = (pc_v & ~32'h7) + 32'd8;
				end
			end

			// resolve cycle, fetch parked on an address that never hits
			@(posedge clk);
			fetch_pc_i <= 32'h0;
			pc_i <= pc_v;
			rj_i <= rj_v;
			rd_i <= rd_v;
			csr_target_i <= pat[base+5];
			stall_i <= ctrl[8];
			csr_flush_i <= ctrl[4];
			decode_i <= dec;
			predict_i <= pred;
			@(negedge clk);

			err_before = errors;
			check_value("br_taken", {31'b0, update_o.br_taken}, {31'b0, exp_flags[12]});
			check_value("br_target", update_o.br_target, exp_target);
			check_value("link_pc", link_pc_o, pc_v + 32'd4);
			if (!rnd) begin
				check_value("flush", {31'b0, update_o.flush}, {31'b0, exp_flags[8]});
				check_value("predict_taken", {31'b0, pred.taken}, {31'b0, exp_flags[4]});
				check_value("ras_redirect", {30'b0, update_o.ras_redirect},
					{30'b0, exp_flags[1:0]});
				// a correct taken prediction already carries the real target
				if (exp_flags[4] && !exp_flags[8]) begin
					check_value("predict_npc", {pred.npc, 2'b00}, exp_target);
				end
			end
			$display("test %0d pc %h: %s", r, pc_v, (errors == err_before) ? "ok" : "FAIL");
		end

		@(posedge clk);
		decode_i <= '0;
		stall_i <= 1'b0;
		csr_flush_i <= 1'b0;
		@(posedge clk);

		$display("tests %0d, checks %0d, errors %0d", NUM_REC, checks, errors);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule : tb_branch_unit

`default_nettype wire
